// File: source/lms_frontend_pkg.sv
package lms_frontend_pkg;

   // LMS ADC bus, one interleaved I/Q word per cycle
   localparam int ADC_W = 12;

   // Sample width the DSP core expects on receive
   // ADC word sits in the top bits, low bits are zero
   localparam int SAMPLE_W = 14;

   // LMS DAC bus, also the width of each transmit I and Q word
   localparam int DAC_W = 12;

   // Slaves on the shared SPI bus
   // Index 0 is the DAC, 1 is LMS1, 2 is LMS2
   localparam int NUM_SPI_DEV = 3;

   typedef logic [ADC_W-1:0]    adc_word_t;    // Raw ADC word
   typedef logic [SAMPLE_W-1:0] sample_t;      // Left-justified receive sample
   typedef logic [DAC_W-1:0]    dac_word_t;    // DAC word, I or Q

endpackage : lms_frontend_pkg

// File: source/rx_iq_capture.sv
`timescale 1ns/1ps

module rx_iq_capture
(
   input  logic                        lms_clk,
   input  logic                        rst_n_i,
   input  logic                        iqsel_i,   // High while adc_d_i carries I
   input  lms_frontend_pkg::adc_word_t adc_d_i,
   output lms_frontend_pkg::sample_t   i_o,
   output lms_frontend_pkg::sample_t   q_o,
   output logic                        valid_o    // One-cycle strobe per pair
);

   import lms_frontend_pkg::*;

   adc_word_t i_pend;      // Last I seen, waits for its Q
   logic      i_held;
   logic      pair_done;   // This cycle's Q completes a pair
   logic      pair_s1;
   sample_t   i_s1;
   sample_t   q_s1;

   assign pair_done = ~iqsel_i & i_held;

   // Stage one control
   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         i_held  <= 1'b0;
         pair_s1 <= 1'b0;
      end
      else
      begin
         // Any Q cycle leaves nothing held, orphan or not
         i_held  <= iqsel_i;
         pair_s1 <= pair_done;
      end
   end

   // Stage one data widened to the DSP sample width
   always_ff @(posedge lms_clk)
   begin
      if (iqsel_i)
         i_pend <= adc_d_i;   // Newer I replaces an unpaired one
      if (pair_done)
      begin
         i_s1 <= {i_pend, {(SAMPLE_W - ADC_W){1'b0}}};
         q_s1 <= {adc_d_i, {(SAMPLE_W - ADC_W){1'b0}}};
      end
   end

   // Stage two pair output register
   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         i_o     <= '0;
         q_o     <= '0;
         valid_o <= 1'b0;
      end
      else
      begin
         valid_o <= pair_s1;
         if (pair_s1)
         begin
            i_o <= i_s1;
            q_o <= q_s1;   // Held until the next pair
         end
      end
   end

   // Completion clears the held I, so two pairs cannot finish back to back
   assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      valid_o |=> !valid_o)
      else $error("rx_iq_capture: valid_o high on two consecutive cycles");

endmodule : rx_iq_capture

// File: source/tx_iq_serializer.sv
`timescale 1ns/1ps

module tx_iq_serializer
(
   input  logic                        lms_clk,
   input  logic                        rst_n_i,
   input  logic                        valid_i,   // Pair strobe
   input  lms_frontend_pkg::dac_word_t i_i,
   input  lms_frontend_pkg::dac_word_t q_i,
   output lms_frontend_pkg::dac_word_t dac_d_o,
   output logic                        iqsel_o    // Low with I, high with Q
);

   import lms_frontend_pkg::*;

   dac_word_t q_hold;    // Q waits here while I is on the bus
   logic      q_phase;   // Next edge moves Q to the bus

   always_ff @(posedge lms_clk)
   begin
      if (valid_i)
         q_hold <= q_i;
   end

   // I goes straight out on the strobe edge, Q follows one edge later
   always_ff @(posedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         dac_d_o <= '0;
         iqsel_o <= 1'b1;
         q_phase <= 1'b0;
      end
      else if (valid_i)
      begin
         dac_d_o <= i_i;
         iqsel_o <= 1'b0;
         q_phase <= 1'b1;
      end
      else if (q_phase)
      begin
         dac_d_o <= q_hold;
         iqsel_o <= 1'b1;
         q_phase <= 1'b0;
      end
      // Otherwise the bus keeps Q with select high
   end

   // A strobe on the Q edge would drop the pending Q
   assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      valid_i |=> !valid_i)
      else $error("tx_iq_serializer: valid_i strobes closer than two cycles");

endmodule : tx_iq_serializer

// File: source/spi_dev_router.sv
`timescale 1ns/1ps

module spi_dev_router
#(
   parameter int NUM_DEV = 1
)
(
   input  logic               lms_clk,      // Only samples the select check
   input  logic               rst_n_i,
   input  logic               sclk_i,       // From the SPI master
   input  logic               mosi_i,
   input  logic [NUM_DEV-1:0] sen_n_i,      // Active-low selects
   output logic               miso_o,
   output logic [NUM_DEV-1:0] dev_sclk_o,
   output logic [NUM_DEV-1:0] dev_mosi_o,
   input  logic [NUM_DEV-1:0] dev_miso_i
);

   logic [NUM_DEV-1:0] dev_sel;

   if (NUM_DEV < 1)
   begin : g_bad_count
      $error("spi_dev_router: NUM_DEV must be at least one");
   end

   assign dev_sel = ~sen_n_i;

   // Unselected devices see a quiet bus
   assign dev_sclk_o = dev_sel & {NUM_DEV{sclk_i}};
   assign dev_mosi_o = dev_sel & {NUM_DEV{mosi_i}};

   // Returns from deselected devices are masked off
   assign miso_o = |(dev_sel & dev_miso_i);

   // Two active selects would short their MISO returns together
   assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      $onehot0(dev_sel))
      else $error("spi_dev_router: more than one SPI select active");

endmodule : spi_dev_router

// File: source/lms_frontend_top.sv
`timescale 1ns/1ps

module lms_frontend_top
(
   input  logic                                        lms_clk,
   input  logic                                        rst_n_i,

   // Receive channel 1
   input  logic                                        rx1_iqsel_i,
   input  lms_frontend_pkg::adc_word_t                 rx1_d_i,
   output lms_frontend_pkg::sample_t                   rx1_i_o,
   output lms_frontend_pkg::sample_t                   rx1_q_o,
   output logic                                        rx1_valid_o,

   // Receive channel 2
   input  logic                                        rx2_iqsel_i,
   input  lms_frontend_pkg::adc_word_t                 rx2_d_i,
   output lms_frontend_pkg::sample_t                   rx2_i_o,
   output lms_frontend_pkg::sample_t                   rx2_q_o,
   output logic                                        rx2_valid_o,

   // Transmit channel 1
   input  logic                                        tx1_valid_i,
   input  lms_frontend_pkg::dac_word_t                 tx1_i_i,
   input  lms_frontend_pkg::dac_word_t                 tx1_q_i,
   output lms_frontend_pkg::dac_word_t                 tx1_d_o,
   output logic                                        tx1_iqsel_o,

   // Transmit channel 2
   input  logic                                        tx2_valid_i,
   input  lms_frontend_pkg::dac_word_t                 tx2_i_i,
   input  lms_frontend_pkg::dac_word_t                 tx2_q_i,
   output lms_frontend_pkg::dac_word_t                 tx2_d_o,
   output logic                                        tx2_iqsel_o,

   // SPI master side, then one bit per device (DAC, LMS1, LMS2)
   input  logic                                        spi_sclk_i,
   input  logic                                        spi_mosi_i,
   input  logic [lms_frontend_pkg::NUM_SPI_DEV-1:0]    spi_sen_n_i,
   output logic                                        spi_miso_o,
   output logic [lms_frontend_pkg::NUM_SPI_DEV-1:0]    dev_sclk_o,
   output logic [lms_frontend_pkg::NUM_SPI_DEV-1:0]    dev_mosi_o,
   input  logic [lms_frontend_pkg::NUM_SPI_DEV-1:0]    dev_miso_i
);

   import lms_frontend_pkg::*;

   // ADC capture, one per LMS receive channel
   rx_iq_capture rx1
   (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .iqsel_i (rx1_iqsel_i),
      .adc_d_i (rx1_d_i),
      .i_o     (rx1_i_o),
      .q_o     (rx1_q_o),
      .valid_o (rx1_valid_o)
   );

   rx_iq_capture rx2
   (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .iqsel_i (rx2_iqsel_i),
      .adc_d_i (rx2_d_i),
      .i_o     (rx2_i_o),
      .q_o     (rx2_q_o),
      .valid_o (rx2_valid_o)
   );

   // DAC serializers
   tx_iq_serializer tx1
   (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .valid_i (tx1_valid_i),
      .i_i     (tx1_i_i),
      .q_i     (tx1_q_i),
      .dac_d_o (tx1_d_o),
      .iqsel_o (tx1_iqsel_o)
   );

   tx_iq_serializer tx2
   (
      .lms_clk (lms_clk),
      .rst_n_i (rst_n_i),
      .valid_i (tx2_valid_i),
      .i_i     (tx2_i_i),
      .q_i     (tx2_q_i),
      .dac_d_o (tx2_d_o),
      .iqsel_o (tx2_iqsel_o)
   );

   spi_dev_router
   #(
      .NUM_DEV (NUM_SPI_DEV)
   )
   spi0
   (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .sclk_i     (spi_sclk_i),
      .mosi_i     (spi_mosi_i),
      .sen_n_i    (spi_sen_n_i),
      .miso_o     (spi_miso_o),
      .dev_sclk_o (dev_sclk_o),
      .dev_mosi_o (dev_mosi_o),
      .dev_miso_i (dev_miso_i)
   );

endmodule : lms_frontend_top

// File: tb/lms_frontend_tb.sv
`timescale 1ns/1ps

module lms_frontend_tb;

   import lms_frontend_pkg::*;

   localparam int RX_DRAIN_TIMEOUT = 40;   // Cycles allowed for the last pulses

   logic lms_clk;
   logic rst_n_i;

   logic                     rx_sel [2];
   adc_word_t                rx_d [2];
   wire  [SAMPLE_W-1:0]      rx_i [2];
   wire  [SAMPLE_W-1:0]      rx_q [2];
   wire                      rx_valid [2];

   logic                     tx_valid [2];
   dac_word_t                tx_i [2];
   dac_word_t                tx_q [2];
   wire  [DAC_W-1:0]         tx_d [2];
   wire                      tx_sel [2];

   logic                     spi_sclk;
   logic                     spi_mosi;
   logic [NUM_SPI_DEV-1:0]   spi_sen_n;
   wire                      spi_miso;
   wire  [NUM_SPI_DEV-1:0]   dev_sclk;
   wire  [NUM_SPI_DEV-1:0]   dev_mosi;
   logic [NUM_SPI_DEV-1:0]   dev_miso;

   integer seed = 32'h5631fa5b;
   int     cycle = 0;
   int     errors = 0;
   int     err_mark = 0;
   int     tests_passed = 0;
   int     tests_failed = 0;
   string  cur_test;

   // Receive model, entries are {due cycle, I, Q}
   adc_word_t   m_pend [2];
   bit          m_held [2];
   logic [59:0] rx_exp0 [$];
   logic [59:0] rx_exp1 [$];
   int          rx_model_cnt [2];
   int          rx_seen [2];

   // Transmit model
   dac_word_t   tx_exp_d [2];
   logic        tx_exp_sel [2];
   dac_word_t   tx_q_pend [2];
   bit          tx_q_due [2];

   lms_frontend_top dut0
   (
      .lms_clk     (lms_clk),
      .rst_n_i     (rst_n_i),
      .rx1_iqsel_i (rx_sel[0]),
      .rx1_d_i     (rx_d[0]),
      .rx1_i_o     (rx_i[0]),
      .rx1_q_o     (rx_q[0]),
      .rx1_valid_o (rx_valid[0]),
      .rx2_iqsel_i (rx_sel[1]),
      .rx2_d_i     (rx_d[1]),
      .rx2_i_o     (rx_i[1]),
      .rx2_q_o     (rx_q[1]),
      .rx2_valid_o (rx_valid[1]),
      .tx1_valid_i (tx_valid[0]),
      .tx1_i_i     (tx_i[0]),
      .tx1_q_i     (tx_q[0]),
      .tx1_d_o     (tx_d[0]),
      .tx1_iqsel_o (tx_sel[0]),
      .tx2_valid_i (tx_valid[1]),
      .tx2_i_i     (tx_i[1]),
      .tx2_q_i     (tx_q[1]),
      .tx2_d_o     (tx_d[1]),
      .tx2_iqsel_o (tx_sel[1]),
      .spi_sclk_i  (spi_sclk),
      .spi_mosi_i  (spi_mosi),
      .spi_sen_n_i (spi_sen_n),
      .spi_miso_o  (spi_miso),
      .dev_sclk_o  (dev_sclk),
      .dev_mosi_o  (dev_mosi),
      .dev_miso_i  (dev_miso)
   );

   initial
   begin
      lms_clk = 1'b0;
      forever #5 lms_clk = ~lms_clk;
   end

   always @(posedge lms_clk)
      cycle <= cycle + 1;

   // Outputs settle on the edge, inputs change 1 ns later
   task automatic next_cycle();
      @(posedge lms_clk);
      #1;
   endtask

   task automatic check_value(string what, logic [31:0] exp, logic [31:0] got);
      assert (got === exp)
      else
      begin
         $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, got);
         errors++;
      end
   endtask

   task automatic start_test(string name);
      cur_test = name;
      err_mark = errors;
   endtask

   task automatic finish_test();
      if (errors == err_mark)
      begin
         tests_passed++;
         $display("PASS %s", cur_test);
      end
      else
      begin
         tests_failed++;
         $display("FAIL %s (%0d errors)", cur_test, errors - err_mark);
      end
   endtask

   // ADC word moved to the top of the DSP sample
   function automatic sample_t widen(adc_word_t w);
      return sample_t'(w) << (SAMPLE_W - ADC_W);
   endfunction

   // Drives one rx cycle and applies the capture rules to it
   task automatic rx_apply(int ch, logic sel, adc_word_t d);
      logic [59:0] e;
      rx_sel[ch] = sel;
      rx_d[ch]   = d;
      if (sel)
      begin
         m_pend[ch] = d;   // Later I wins
         m_held[ch] = 1'b1;
      end
      else if (m_held[ch])
      begin
         // Sampled on the next edge, strobe one edge after that
         e = {32'(cycle + 2), widen(m_pend[ch]), widen(d)};
         if (ch == 0)
            rx_exp0.push_back(e);
         else
            rx_exp1.push_back(e);
         m_held[ch] = 1'b0;
         rx_model_cnt[ch]++;
      end
   endtask

   task automatic rx_check(int ch);
      logic [59:0] e;
      bit          have;
      bit          due;
      have = 1'b0;
      e    = '0;
      if (ch == 0 && rx_exp0.size() != 0)
      begin
         e    = rx_exp0[0];
         have = 1'b1;
      end
      else if (ch == 1 && rx_exp1.size() != 0)
      begin
         e    = rx_exp1[0];
         have = 1'b1;
      end
      due = have && (e[59:28] == cycle);
      check_value($sformatf("rx%0d valid", ch + 1), due, rx_valid[ch]);
      if (rx_valid[ch])
         rx_seen[ch]++;
      if (due)
      begin
         check_value($sformatf("rx%0d i", ch + 1), e[27:14], rx_i[ch]);
         check_value($sformatf("rx%0d q", ch + 1), e[13:0], rx_q[ch]);
         if (ch == 0)
            void'(rx_exp0.pop_front());
         else
            void'(rx_exp1.pop_front());
      end
   endtask

   // Channel 2 stays on orphan Q cycles unless both are exercised
   task automatic run_rx(int n, bit both);
      int wait_cnt;
      rx_model_cnt = '{0, 0};
      rx_seen      = '{0, 0};
      for (int k = 0; k < n; k++)
      begin
         next_cycle();
         rx_check(0);
         rx_check(1);
         rx_apply(0, $random(seed), $random(seed));
         rx_apply(1, both ? $random(seed) : 1'b0, $random(seed));
      end
      wait_cnt = 0;
      while ((rx_exp0.size() != 0 || rx_exp1.size() != 0 || wait_cnt < 3)
             && wait_cnt < RX_DRAIN_TIMEOUT)
      begin
         next_cycle();
         rx_check(0);
         rx_check(1);
         rx_apply(0, 1'b0, $random(seed));
         rx_apply(1, 1'b0, $random(seed));
         wait_cnt++;
      end
      if (rx_exp0.size() != 0 || rx_exp1.size() != 0)
      begin
         $display("ERROR %s: timed out waiting for rx valid_o", cur_test);
         errors++;
      end
      check_value("rx1 pulse count", rx_model_cnt[0], rx_seen[0]);
      check_value("rx2 pulse count", rx_model_cnt[1], rx_seen[1]);
   endtask

   task automatic run_tx(int n);
      int        gap [2];
      logic      strobe;
      dac_word_t iw;
      dac_word_t qw;
      for (int ch = 0; ch < 2; ch++)
      begin
         tx_exp_d[ch]   = '0;   // Reset state of the bus
         tx_exp_sel[ch] = 1'b1;
         tx_q_due[ch]   = 1'b0;
         gap[ch]        = $random(seed) & 3;
      end
      for (int k = 0; k < n; k++)
      begin
         next_cycle();
         for (int ch = 0; ch < 2; ch++)
         begin
            check_value($sformatf("tx%0d dac", ch + 1), tx_exp_d[ch], tx_d[ch]);
            check_value($sformatf("tx%0d iqsel", ch + 1), tx_exp_sel[ch], tx_sel[ch]);
            strobe = (gap[ch] == 0) && (k < n - 4);
            iw     = $random(seed);
            qw     = $random(seed);
            tx_valid[ch] = strobe;
            tx_i[ch]     = iw;
            tx_q[ch]     = qw;
            if (strobe)
            begin
               tx_exp_d[ch]   = iw;   // I on the strobe edge
               tx_exp_sel[ch] = 1'b0;
               tx_q_pend[ch]  = qw;
               tx_q_due[ch]   = 1'b1;
               gap[ch]        = 1 + ($random(seed) & 3);
            end
            else
            begin
               if (gap[ch] > 0)
                  gap[ch]--;
               if (tx_q_due[ch])
               begin
                  tx_exp_d[ch]   = tx_q_pend[ch];
                  tx_exp_sel[ch] = 1'b1;
                  tx_q_due[ch]   = 1'b0;
               end
            end
         end
      end
   endtask

   task automatic run_spi(int n);
      int                     r;
      logic [NUM_SPI_DEV-1:0] exp_sclk;
      logic [NUM_SPI_DEV-1:0] exp_mosi;
      logic                   exp_miso;
      for (int k = 0; k < n; k++)
      begin
         next_cycle();
         r = $random(seed) & 3;   // None, or one of three devices
         spi_sen_n = (r == 0) ? '1 : ~(NUM_SPI_DEV'(1) << (r - 1));
         spi_sclk  = $random(seed);
         spi_mosi  = $random(seed);
         dev_miso  = $random(seed);
         #2;
         exp_sclk = '0;
         exp_mosi = '0;
         exp_miso = 1'b0;
         for (int d = 0; d < NUM_SPI_DEV; d++)
         begin
            if (!spi_sen_n[d])
            begin
               exp_sclk[d] = spi_sclk;
               exp_mosi[d] = spi_mosi;
               exp_miso    = exp_miso | dev_miso[d];
            end
         end
         check_value("dev_sclk", exp_sclk, dev_sclk);
         check_value("dev_mosi", exp_mosi, dev_mosi);
         check_value("spi_miso", exp_miso, spi_miso);
      end
      next_cycle();
      spi_sen_n = '1;
   endtask

   initial
   begin
      rst_n_i   = 1'b0;
      rx_sel    = '{1'b0, 1'b0};
      rx_d      = '{'0, '0};
      tx_valid  = '{1'b0, 1'b0};
      tx_i      = '{'0, '0};
      tx_q      = '{'0, '0};
      spi_sclk  = 1'b0;
      spi_mosi  = 1'b0;
      spi_sen_n = '1;
      dev_miso  = '0;
      m_held    = '{1'b0, 1'b0};
      m_pend    = '{'0, '0};

      repeat (8) next_cycle();
      rst_n_i = 1'b1;

      start_test("reset_state");
      for (int ch = 0; ch < 2; ch++)
      begin
         check_value($sformatf("rx%0d valid", ch + 1), 1'b0, rx_valid[ch]);
         check_value($sformatf("rx%0d i", ch + 1), '0, rx_i[ch]);
         check_value($sformatf("rx%0d q", ch + 1), '0, rx_q[ch]);
         check_value($sformatf("tx%0d dac", ch + 1), '0, tx_d[ch]);
         check_value($sformatf("tx%0d iqsel", ch + 1), 1'b1, tx_sel[ch]);
      end
      finish_test();

      start_test("rx_pairing");
      run_rx(400, 1'b0);
      finish_test();

      start_test("rx_independence");
      run_rx(400, 1'b1);
      finish_test();

      start_test("tx_order");
      run_tx(300);
      finish_test();

      start_test("spi_routing");
      run_spi(200);
      finish_test();

      $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
               tests_passed, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule : lms_frontend_tb

// File: lms_frontend.f
source/lms_frontend_pkg.sv
source/rx_iq_capture.sv
source/tx_iq_serializer.sv
source/spi_dev_router.sv
source/lms_frontend_top.sv
tb/lms_frontend_tb.sv

// File: Bender.yml
package:
  name: lms_frontend

sources:
  # Package first, then the modules, top level last
  - files:
      - source/lms_frontend_pkg.sv
      - source/rx_iq_capture.sv
      - source/tx_iq_serializer.sv
      - source/spi_dev_router.sv
      - source/lms_frontend_top.sv

  # Testbench, top module lms_frontend_tb
  - target: test
    files:
      - tb/lms_frontend_tb.sv
